// File: sifhPkg.sv
//**************************************************
// shared sizes, pass kind and APB register map
// countWidth follows the default DataNum and AcqNum
//**************************************************

package sifhPkg;

    //**************************************************
    // default sizes, overridden from the top level
    //**************************************************
    // timestamp width
    localparam int defNp = 10;
    // coarse bin address width, must stay below defNp
    localparam int defNb = 6;
    localparam int defPixelNum = 4;
    // samples per pixel per acquisition
    localparam int defDataNum = 4;
    // acquisitions per frame
    localparam int defAcqNum = 8;

    // one bin can collect every sample of its pixel in a frame
    localparam int countWidth = $clog2(defDataNum * defAcqNum + 1);

    // frame kind, coarse first after reset
    typedef enum logic {
        COARSE = 1'b0,
        FINE   = 1'b1
    } passKind_t;

    //**************************************************
    // APB register map, word addresses
    //**************************************************
    localparam int apbAddrWidth = 8;
    localparam int apbDataWidth = 32;
    // number of fine results latched, wraps at 2^16
    localparam int regStatus = 0;
    // pixel k result sits at regResultBase + k
    localparam int regResultBase = 1;
    localparam int statusWidth = 16;

endpackage

// File: tdcFilter.sv
//**************************************************
// samples arrive pixel-major, one per cycle, no stall
// fine bins wrap to Nb bits relative to winLow
//**************************************************
`timescale 1ns/1ps

module tdcFilter import sifhPkg::*; #(
    parameter int Np = defNp,
    parameter int Nb = defNb,
    parameter int PixelNum = defPixelNum,
    parameter int DataNum = defDataNum,
    parameter int AcqNum = defAcqNum,
    localparam int pixW = (PixelNum > 1) ? $clog2(PixelNum) : 1
) (
    input  logic                   clk,
    input  logic                   combin_res,
    input  logic                   wrEn,
    input  logic [Np-1:0]          data,
    input  logic                   passFine,
    input  logic [PixelNum*Np-1:0] winLow,
    input  logic [PixelNum*Np-1:0] winHigh,
    output logic                   binValid,
    output logic [Nb-1:0]          binAddr,
    output logic [pixW-1:0]        binPixel,
    output logic                   framePar,
    output logic                   lastSample
);

    localparam int dataW = (DataNum > 1) ? $clog2(DataNum) : 1;
    localparam int acqW = (AcqNum > 1) ? $clog2(AcqNum) : 1;

    logic [dataW-1:0] sampleCnt;
    logic [pixW-1:0]  pixelCnt;
    logic [acqW-1:0]  acqCnt;
    // parity of the frame in progress
    logic             curPar;
    logic             endOfPixel;
    logic             endOfAcq;
    logic             lastInFrame;
    logic [Np-1:0]    lowEdge;
    logic [Np-1:0]    highEdge;
    logic [Np-1:0]    relData;
    logic             inWindow;

    // position of the current sample in the frame
    assign endOfPixel = (sampleCnt == dataW'(DataNum - 1));
    assign endOfAcq = endOfPixel && (pixelCnt == pixW'(PixelNum - 1));
    assign lastInFrame = endOfAcq && (acqCnt == acqW'(AcqNum - 1));

    // window of the pixel owning this sample, edges inclusive
    assign lowEdge = winLow[pixelCnt*Np +: Np];
    assign highEdge = winHigh[pixelCnt*Np +: Np];
    assign inWindow = (data >= lowEdge) && (data <= highEdge);
    assign relData = data - lowEdge;

    //**************************************************
    // sample / pixel / acquisition counters
    //**************************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixelCnt <= '0;
            acqCnt <= '0;
            curPar <= 1'b0;
        end else if (wrEn) begin
            sampleCnt <= endOfPixel ? '0 : sampleCnt + 1'b1;
            if (endOfPixel) begin
                pixelCnt <= endOfAcq ? '0 : pixelCnt + 1'b1;
            end
            if (endOfAcq) begin
                acqCnt <= lastInFrame ? '0 : acqCnt + 1'b1;
            end
            // next frame gets the other parity
            if (lastInFrame) begin
                curPar <= ~curPar;
            end
        end
    end

    // strobes, one cycle behind the sample
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid <= 1'b0;
            lastSample <= 1'b0;
            framePar <= 1'b0;
        end else begin
            // out-of-window fine samples dropped here
            binValid <= wrEn && (!passFine || inWindow);
            // frame end travels even for a dropped sample
            lastSample <= wrEn && lastInFrame;
            if (wrEn) begin
                framePar <= curPar;
            end
        end
    end

    // bin address, coarse takes the top bits
    always_ff @(posedge clk) begin
        if (wrEn) begin
            binAddr <= passFine ? relData[Nb-1:0] : data[Np-1 -: Nb];
            binPixel <= pixelCnt;
        end
    end

endmodule

// File: histogramRam.sv
//**************************************************
// count memory has no reset, live bits and tags gate it
// needs idle cycles between frames, no hit with frameEnd
//**************************************************
`timescale 1ns/1ps

module histogramRam import sifhPkg::*; #(
    parameter int Nb = defNb,
    parameter int PixelNum = defPixelNum,
    localparam int pixW = (PixelNum > 1) ? $clog2(PixelNum) : 1
) (
    input  logic                  clk,
    input  logic                  combin_res,
    input  logic                  binValid,
    input  logic [Nb-1:0]         binAddr,
    input  logic [pixW-1:0]       binPixel,
    input  logic                  framePar,
    input  logic                  lastSample,
    output logic                  hitValid,
    output logic [Nb-1:0]         hitAddr,
    output logic [pixW-1:0]       hitPixel,
    output logic [countWidth-1:0] hitCount,
    output logic                  frameEnd
);

    localparam int idxW = pixW + Nb;
    localparam int depth = 1 << idxW;

    // one histogram of 2^Nb bins per pixel
    logic [countWidth-1:0] countMem [depth];
    // parity of the frame that last wrote each bin
    logic [depth-1:0]      tagBits;
    // bin written in this frame or the one before
    logic [depth-1:0]      liveBits;
    logic                  hitPar;
    logic [idxW-1:0]       rdIdx;
    logic [idxW-1:0]       wrIdx;
    logic                  fwdHit;
    logic [countWidth-1:0] baseCount;

    assign rdIdx = {binPixel, binAddr};
    assign wrIdx = {hitPixel, hitAddr};

    // previous hit not yet in memory, same bin and frame
    assign fwdHit = hitValid && (wrIdx == rdIdx) && (hitPar == framePar);

    //**************************************************
    // read side of the read-modify-write
    //**************************************************
    always_comb begin
        if (fwdHit) begin
            baseCount = hitCount;
        end else if (liveBits[rdIdx] && (tagBits[rdIdx] == framePar)) begin
            baseCount = countMem[rdIdx];
        end else begin
            // stale bin from an older frame reads as empty
            baseCount = '0;
        end
    end

    // hit stage and lazy clear of the live bits
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            hitValid <= 1'b0;
            frameEnd <= 1'b0;
            liveBits <= '0;
        end else begin
            hitValid <= binValid;
            frameEnd <= lastSample;
            // bins untouched in the ending frame go dead
            if (frameEnd) begin
                for (int i = 0; i < depth; i++) begin
                    if (tagBits[i] != hitPar) begin
                        liveBits[i] <= 1'b0;
                    end
                end
            end
            // write-back of the last hit wins over the clear
            if (hitValid) begin
                liveBits[wrIdx] <= 1'b1;
            end
        end
    end

    // payload and the write port
    always_ff @(posedge clk) begin
        hitAddr <= binAddr;
        hitPixel <= binPixel;
        hitPar <= framePar;
        hitCount <= baseCount + 1'b1;
        if (hitValid) begin
            countMem[wrIdx] <= hitCount;
            tagBits[wrIdx] <= hitPar;
        end
    end

endmodule

// File: peakDetector.sv
//**************************************************
// ties keep the bin that first reached the top count
// frameEnd arrives with the last hit, folded in here
//**************************************************
`timescale 1ns/1ps

module peakDetector import sifhPkg::*; #(
    parameter int Np = defNp,
    parameter int Nb = defNb,
    parameter int PixelNum = defPixelNum,
    localparam int pixW = (PixelNum > 1) ? $clog2(PixelNum) : 1
) (
    input  logic                   clk,
    input  logic                   combin_res,
    input  logic                   hitValid,
    input  logic [Nb-1:0]          hitAddr,
    input  logic [pixW-1:0]        hitPixel,
    input  logic [countWidth-1:0]  hitCount,
    input  logic                   frameEnd,
    output logic                   passFine,
    output logic [PixelNum*Np-1:0] winLow,
    output logic [PixelNum*Np-1:0] winHigh,
    output logic [PixelNum*Np-1:0] resultBus,
    output logic                   resultStrobe
);

    // top of the timestamp range and half window SB
    localparam logic [Np-1:0] topVal = {Np{1'b1}};
    localparam logic [Np-1:0] halfSpan = Np'(1) << (Nb - 1);

    passKind_t             pass;
    logic [countWidth-1:0] maxCount [PixelNum];
    logic [Nb-1:0]         maxBin [PixelNum];
    // peak including a hit in the current cycle
    logic [Nb-1:0]         peakBin [PixelNum];
    logic [Np-1:0]         centre [PixelNum];
    logic [Np-1:0]         nextLow [PixelNum];
    logic [Np-1:0]         nextHigh [PixelNum];

    assign passFine = (pass == FINE);

    //**************************************************
    // window rule around the coarse peak
    //**************************************************
    always_comb begin
        for (int k = 0; k < PixelNum; k++) begin
            peakBin[k] = maxBin[k];
            if (hitValid && (hitPixel == pixW'(k)) && (hitCount > maxCount[k])) begin
                peakBin[k] = hitAddr;
            end
            // CH, coarse bin back in timestamp units
            centre[k] = Np'(peakBin[k]) << (Np - Nb);
            if (centre[k] <= halfSpan) begin
                // clamped at zero
                nextLow[k] = '0;
                nextHigh[k] = halfSpan << 1;
            end else if (centre[k] > topVal - (halfSpan << 1) - 1'b1) begin
                // clamped at the top of the range
                nextLow[k] = (centre[k] << 1) - topVal;
                nextHigh[k] = topVal;
            end else begin
                nextLow[k] = centre[k] - halfSpan;
                nextHigh[k] = centre[k] + halfSpan;
            end
        end
    end

    // running maxima, pass state and windows
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            pass <= COARSE;
            resultStrobe <= 1'b0;
            winLow <= '0;
            winHigh <= '0;
            for (int k = 0; k < PixelNum; k++) begin
                maxCount[k] <= '0;
                maxBin[k] <= '0;
            end
        end else begin
            resultStrobe <= 1'b0;
            if (frameEnd) begin
                for (int k = 0; k < PixelNum; k++) begin
                    maxCount[k] <= '0;
                    maxBin[k] <= '0;
                    if (pass == COARSE) begin
                        winLow[k*Np +: Np] <= nextLow[k];
                        winHigh[k*Np +: Np] <= nextHigh[k];
                    end
                end
                resultStrobe <= (pass == FINE);
                pass <= (pass == COARSE) ? FINE : COARSE;
            end else if (hitValid && (hitCount > maxCount[hitPixel])) begin
                // strictly greater, earlier bin keeps a tie
                maxCount[hitPixel] <= hitCount;
                maxBin[hitPixel] <= hitAddr;
            end
        end
    end

    // fine result is lower edge plus fine peak
    always_ff @(posedge clk) begin
        if (frameEnd && (pass == FINE)) begin
            for (int k = 0; k < PixelNum; k++) begin
                resultBus[k*Np +: Np] <= winLow[k*Np +: Np] + Np'(peakBin[k]);
            end
        end
    end

endmodule

// File: apbResultRegs.sv
//**************************************************
// read-only APB slave, zero wait states, pWdata ignored
// writes and addresses above PixelNum give pSlverr
//**************************************************
`timescale 1ns/1ps

module apbResultRegs import sifhPkg::*; #(
    parameter int Np = defNp,
    parameter int PixelNum = defPixelNum
) (
    input  logic                    clk,
    input  logic                    combin_res,
    input  logic [PixelNum*Np-1:0]  resultBus,
    input  logic                    resultStrobe,
    input  logic                    pSel,
    input  logic                    pEnable,
    input  logic                    pWrite,
    input  logic [apbAddrWidth-1:0] pAddr,
    input  logic [apbDataWidth-1:0] pWdata,
    output logic [apbDataWidth-1:0] pRdata,
    output logic                    pReady,
    output logic                    pSlverr
);

    logic [Np-1:0]          results [PixelNum];
    logic [statusWidth-1:0] resultCnt;
    logic                   accessPh;
    logic                   badAddr;
    logic [apbDataWidth-1:0] rdMux;

    // result snapshot and count, one update per fine frame
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            resultCnt <= '0;
            for (int k = 0; k < PixelNum; k++) begin
                results[k] <= '0;
            end
        end else if (resultStrobe) begin
            resultCnt <= resultCnt + 1'b1;
            for (int k = 0; k < PixelNum; k++) begin
                results[k] <= resultBus[k*Np +: Np];
            end
        end
    end

    //**************************************************
    // APB decode
    //**************************************************
    assign accessPh = pSel && pEnable;
    assign badAddr = (pAddr > apbAddrWidth'(PixelNum));
    assign pReady = 1'b1;
    assign pSlverr = accessPh && (pWrite || badAddr);

    always_comb begin
        rdMux = '0;
        if (pAddr == apbAddrWidth'(regStatus)) begin
            rdMux = apbDataWidth'(resultCnt);
        end
        for (int k = 0; k < PixelNum; k++) begin
            if (pAddr == apbAddrWidth'(regResultBase + k)) begin
                rdMux = apbDataWidth'(results[k]);
            end
        end
    end

    // read data only in a good access phase
    assign pRdata = (accessPh && !pSlverr) ? rdMux : '0;

endmodule

// File: sifhTop.sv
//**************************************************
// two-pass SiFH peak finder, results read over APB
// Nb must stay below Np, DataNum*AcqNum fits countWidth
//**************************************************
`timescale 1ns/1ps

module sifhTop import sifhPkg::*; #(
    parameter int Np = defNp,
    parameter int Nb = defNb,
    parameter int PixelNum = defPixelNum,
    parameter int DataNum = defDataNum,
    parameter int AcqNum = defAcqNum,
    localparam int pixW = (PixelNum > 1) ? $clog2(PixelNum) : 1
) (
    input  logic                    clk,
    input  logic                    combin_res,
    input  logic                    wrEn,
    input  logic [Np-1:0]           data,
    input  logic                    pSel,
    input  logic                    pEnable,
    input  logic                    pWrite,
    input  logic [apbAddrWidth-1:0] pAddr,
    input  logic [apbDataWidth-1:0] pWdata,
    output logic [apbDataWidth-1:0] pRdata,
    output logic                    pReady,
    output logic                    pSlverr
);

    // filter to histogram
    logic                   binValid;
    logic [Nb-1:0]          binAddr;
    logic [pixW-1:0]        binPixel;
    logic                   framePar;
    logic                   lastSample;
    // histogram to peak tracker
    logic                   hitValid;
    logic [Nb-1:0]          hitAddr;
    logic [pixW-1:0]        hitPixel;
    logic [countWidth-1:0]  hitCount;
    logic                   frameEnd;
    // feedback of windows and pass, results out
    logic                   passFine;
    logic [PixelNum*Np-1:0] winLow;
    logic [PixelNum*Np-1:0] winHigh;
    logic [PixelNum*Np-1:0] resultBus;
    logic                   resultStrobe;

    tdcFilter #(
        .Np(Np), .Nb(Nb), .PixelNum(PixelNum), .DataNum(DataNum), .AcqNum(AcqNum)
    ) i_tdcFilter (
        .clk(clk), .combin_res(combin_res), .wrEn(wrEn), .data(data),
        .passFine(passFine), .winLow(winLow), .winHigh(winHigh),
        .binValid(binValid), .binAddr(binAddr), .binPixel(binPixel),
        .framePar(framePar), .lastSample(lastSample)
    );

    histogramRam #(.Nb(Nb), .PixelNum(PixelNum)) i_histogramRam (
        .clk(clk), .combin_res(combin_res), .binValid(binValid), .binAddr(binAddr),
        .binPixel(binPixel), .framePar(framePar), .lastSample(lastSample),
        .hitValid(hitValid), .hitAddr(hitAddr), .hitPixel(hitPixel),
        .hitCount(hitCount), .frameEnd(frameEnd)
    );

    peakDetector #(.Np(Np), .Nb(Nb), .PixelNum(PixelNum)) i_peakDetector (
        .clk(clk), .combin_res(combin_res), .hitValid(hitValid), .hitAddr(hitAddr),
        .hitPixel(hitPixel), .hitCount(hitCount), .frameEnd(frameEnd),
        .passFine(passFine), .winLow(winLow), .winHigh(winHigh),
        .resultBus(resultBus), .resultStrobe(resultStrobe)
    );

    apbResultRegs #(.Np(Np), .PixelNum(PixelNum)) i_apbResultRegs (
        .clk(clk), .combin_res(combin_res), .resultBus(resultBus),
        .resultStrobe(resultStrobe), .pSel(pSel), .pEnable(pEnable),
        .pWrite(pWrite), .pAddr(pAddr), .pWdata(pWdata), .pRdata(pRdata),
        .pReady(pReady), .pSlverr(pSlverr)
    );

endmodule

// File: sifh_props.sv
//**************************************************
// bound into sifhTop, sees the APB port and both pipeline valids
//**************************************************
`timescale 1ns/1ps

module sifhProps (
    input logic clk,
    input logic combin_res,
    input logic pSel,
    input logic pEnable,
    input logic pReady,
    input logic pSlverr,
    input logic binValid,
    input logic hitValid
);

    // failure tally, read by the testbench top
    int assertErrs = 0;

    // zero wait state slave
    readyHigh: assert property (@(posedge clk) disable iff (!combin_res) pReady)
        else begin
            assertErrs++;
            $error("pReady went low");
        end

    // error response only in the access phase
    slverrInAccess: assert property (@(posedge clk) disable iff (!combin_res)
        pSlverr |-> (pSel && pEnable))
        else begin
            assertErrs++;
            $error("pSlverr high outside the access phase");
        end

    // histogram stage is exactly one cycle deep
    hitFollowsBin: assert property (@(posedge clk) disable iff (!combin_res)
        hitValid == $past(binValid))
        else begin
            assertErrs++;
            $error("hitValid does not follow binValid by one cycle");
        end

endmodule

bind sifhTop sifhProps i_sifhProps (
    .clk(clk), .combin_res(combin_res), .pSel(pSel), .pEnable(pEnable),
    .pReady(pReady), .pSlverr(pSlverr), .binValid(binValid), .hitValid(hitValid)
);

// File: sifhChecker.sv
//**************************************************
// reference model of both passes, fed from the DUT inputs
// compares every APB access phase, reads at least 4 cycles after a frame
//**************************************************
`timescale 1ns/1ps

module sifhChecker import sifhPkg::*; #(
    parameter int Np = defNp,
    parameter int Nb = defNb,
    parameter int PixelNum = defPixelNum,
    parameter int DataNum = defDataNum,
    parameter int AcqNum = defAcqNum
) (
    input  logic                    clk,
    input  logic                    combin_res,
    input  logic                    wrEn,
    input  logic [Np-1:0]           data,
    input  logic                    pSel,
    input  logic                    pEnable,
    input  logic                    pWrite,
    input  logic [apbAddrWidth-1:0] pAddr,
    input  logic [apbDataWidth-1:0] pRdata,
    input  logic                    pSlverr,
    output int                      checkCount,
    output int                      errCount
);

    localparam int binNum = 1 << Nb;
    localparam int frameLen = PixelNum * DataNum * AcqNum;
    // SB and top of the timestamp range
    localparam int halfSpan = 1 << (Nb - 1);
    localparam int topVal = (1 << Np) - 1;

    int hist [PixelNum][binNum];
    int maxCnt [PixelNum];
    int maxBin [PixelNum];
    int winLow [PixelNum];
    int winHigh [PixelNum];
    int expResult [PixelNum];
    int expStatus;
    int sampleIdx;
    bit fineNow;

    // histograms and running peaks back to empty
    function void clearFrame();
        for (int k = 0; k < PixelNum; k++) begin
            maxCnt[k] = 0;
            maxBin[k] = 0;
            for (int b = 0; b < binNum; b++) begin
                hist[k][b] = 0;
            end
        end
        sampleIdx = 0;
    endfunction

    function void resetModel();
        clearFrame();
        for (int k = 0; k < PixelNum; k++) begin
            winLow[k] = 0;
            winHigh[k] = 0;
            expResult[k] = 0;
        end
        expStatus = 0;
        fineNow = 1'b0;
    endfunction

    //**************************************************
    // frame end, window rule or result
    //**************************************************
    function void closeFrame();
        int ch;
        for (int k = 0; k < PixelNum; k++) begin
            if (!fineNow) begin
                ch = maxBin[k] << (Np - Nb);
                if (ch <= halfSpan) begin
                    winLow[k] = 0;
                    winHigh[k] = 2 * halfSpan;
                end else if (ch > topVal - 2 * halfSpan - 1) begin
                    winLow[k] = 2 * ch - topVal;
                    winHigh[k] = topVal;
                end else begin
                    winLow[k] = ch - halfSpan;
                    winHigh[k] = ch + halfSpan;
                end
            end else begin
                expResult[k] = (winLow[k] + maxBin[k]) % (topVal + 1);
            end
        end
        if (fineNow) begin
            expStatus = (expStatus + 1) % (1 << statusWidth);
        end
        fineNow = !fineNow;
        clearFrame();
    endfunction

    function void takeSample(input int ts);
        int pix;
        int bin;
        bit keep;
        pix = (sampleIdx / DataNum) % PixelNum;
        keep = 1'b1;
        bin = 0;
        if (!fineNow) begin
            bin = ts >> (Np - Nb);
        end else begin
            // inclusive window, bin wraps to Nb bits
            keep = (ts >= winLow[pix]) && (ts <= winHigh[pix]);
            if (keep) begin
                bin = (ts - winLow[pix]) % binNum;
            end
        end
        if (keep) begin
            hist[pix][bin]++;
            // strictly greater so the first bin keeps a tie
            if (hist[pix][bin] > maxCnt[pix]) begin
                maxCnt[pix] = hist[pix][bin];
                maxBin[pix] = bin;
            end
        end
        sampleIdx++;
        if (sampleIdx == frameLen) begin
            closeFrame();
        end
    endfunction

    //**************************************************
    // APB comparison
    //**************************************************
    function void compareRead();
        logic [apbDataWidth-1:0] expData;
        logic                    expErr;
        string                   regName;
        checkCount++;
        expErr = pWrite || (pAddr > apbAddrWidth'(PixelNum));
        if (pSlverr !== expErr) begin
            errCount++;
            $display("ERROR pSlverr at address %h: expected %h, actual %h",
                     pAddr, expErr, pSlverr);
        end else if (!expErr) begin
            if (pAddr == apbAddrWidth'(regStatus)) begin
                expData = apbDataWidth'(expStatus);
                regName = "status";
            end else begin
                expData = apbDataWidth'(expResult[pAddr - regResultBase]);
                regName = $sformatf("result%0d", pAddr - regResultBase);
            end
            if (pRdata !== expData) begin
                errCount++;
                $display("ERROR %s: expected %h, actual %h", regName, expData, pRdata);
            end
        end
    endfunction

    initial begin
        checkCount = 0;
        errCount = 0;
        resetModel();
    end

    // sees the same edge values the DUT samples
    always @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            resetModel();
        end else begin
            if (pSel && pEnable) begin
                compareRead();
            end
            if (wrEn) begin
                takeSample(int'(data));
            end
        end
    end

endmodule

// File: sifhTb.sv
//**************************************************
// seeded random frames in coarse/fine pairs, APB readout
// sample stream never stalls, gaps of 4+ cycles between frames
//**************************************************
`timescale 1ns/1ps

module sifhTb import sifhPkg::*;;

    localparam int Np = defNp;
    localparam int Nb = defNb;
    localparam int PixelNum = defPixelNum;
    localparam int DataNum = defDataNum;
    localparam int AcqNum = defAcqNum;
    localparam int topVal = (1 << Np) - 1;

    //**************************************************
    // run length bound
    //**************************************************
    localparam int samplesPerFrame = PixelNum * DataNum * AcqNum;
    // worst case random idles plus frame gap and read wait
    localparam int gapsPerFrame = 2 * samplesPerFrame + 16;
    localparam int readsPerFrame = 3 * (PixelNum + 1);
    // 8 pairs plus room for the reset and error tests
    localparam int frameCount = 16 + 2;
    localparam int cycleLimit =
        frameCount * (samplesPerFrame + gapsPerFrame + readsPerFrame) * 2;

    logic                    clk;
    logic                    combin_res;
    logic                    wrEn;
    logic [Np-1:0]           data;
    logic                    pSel;
    logic                    pEnable;
    logic                    pWrite;
    logic [apbAddrWidth-1:0] pAddr;
    logic [apbDataWidth-1:0] pWdata;
    logic [apbDataWidth-1:0] pRdata;
    logic                    pReady;
    logic                    pSlverr;

    int          checkCount;
    int          errCount;
    int          errAtStart;
    int          testsRun;
    int          testsFailed;
    int          cycleCount;
    // true arrival time per pixel for the current pair
    int          arrival [PixelNum];

    sifhTop #(
        .Np(Np), .Nb(Nb), .PixelNum(PixelNum), .DataNum(DataNum), .AcqNum(AcqNum)
    ) i_sifhTop (
        .clk(clk), .combin_res(combin_res), .wrEn(wrEn), .data(data),
        .pSel(pSel), .pEnable(pEnable), .pWrite(pWrite), .pAddr(pAddr),
        .pWdata(pWdata), .pRdata(pRdata), .pReady(pReady), .pSlverr(pSlverr)
    );

    sifhChecker #(
        .Np(Np), .Nb(Nb), .PixelNum(PixelNum), .DataNum(DataNum), .AcqNum(AcqNum)
    ) i_sifhChecker (
        .clk(clk), .combin_res(combin_res), .wrEn(wrEn), .data(data),
        .pSel(pSel), .pEnable(pEnable), .pWrite(pWrite), .pAddr(pAddr),
        .pRdata(pRdata), .pSlverr(pSlverr),
        .checkCount(checkCount), .errCount(errCount)
    );

    // 100 ns period
    always #50 clk = ~clk;

    // hang guard
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Simulation failed");
            $finish;
        end
    end

    //**************************************************
    // stimulus helpers
    //**************************************************
    task idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            wrEn <= 1'b0;
        end
    endtask

    task pushSample(input int ts);
        @(posedge clk);
        wrEn <= 1'b1;
        data <= Np'(ts);
    endtask

    // setup then access phase, zero wait states
    task apbAccess(input logic wr, input int addr);
        @(posedge clk);
        pSel <= 1'b1;
        pEnable <= 1'b0;
        pWrite <= wr;
        pAddr <= apbAddrWidth'(addr);
        pWdata <= $urandom;
        @(posedge clk);
        pEnable <= 1'b1;
        @(posedge clk);
        pSel <= 1'b0;
        pEnable <= 1'b0;
        pWrite <= 1'b0;
    endtask

    task readAllRegs();
        for (int a = 0; a <= PixelNum; a++) begin
            apbAccess(1'b0, a);
        end
    endtask

    // 0 random, 1 near zero, otherwise mixed edges
    task pickArrivals(input int mode);
        int lowT;
        int highT;
        for (int p = 0; p < PixelNum; p++) begin
            lowT = int'($urandom % 16);
            highT = topVal - int'($urandom % 16);
            case (mode)
                0: arrival[p] = int'($urandom % (topVal + 1));
                1: arrival[p] = lowT;
                default: arrival[p] = (p % 2) ? highT : lowT;
            endcase
        end
    endtask

    // one frame, pixel-major per acquisition
    task sendFrame(input int noisePct);
        int ts;
        for (int a = 0; a < AcqNum; a++) begin
            for (int p = 0; p < PixelNum; p++) begin
                for (int s = 0; s < DataNum; s++) begin
                    if ($urandom % 4 == 0) begin
                        idleCycles(1 + int'($urandom % 2));
                    end
                    if ($urandom % 100 < noisePct) begin
                        ts = int'($urandom % (topVal + 1));
                    end else begin
                        // jitter of +-3 around the true time
                        ts = arrival[p] + int'($urandom % 7) - 3;
                        if (ts < 0) begin
                            ts = 0;
                        end
                        if (ts > topVal) begin
                            ts = topVal;
                        end
                    end
                    pushSample(ts);
                end
            end
        end
        idleCycles(4 + int'($urandom % 3));
    endtask

    task runPassPair(input int noiseCoarse, input int noiseFine);
        sendFrame(noiseCoarse);
        sendFrame(noiseFine);
        idleCycles(6);
        readAllRegs();
    endtask

    task beginTest();
        errAtStart = errCount;
    endtask

    // half a cycle later the checker has seen the last access
    task endTest(input string name);
        @(negedge clk);
        testsRun++;
        if (errCount != errAtStart) begin
            testsFailed++;
        end
        $display("test %s: %s, %0d errors", name,
                 (errCount == errAtStart) ? "ok" : "FAIL", errCount - errAtStart);
    endtask

    //**************************************************
    // test sequence
    //**************************************************
    initial begin
        clk = 1'b0;
        combin_res = 1'b0;
        wrEn = 1'b0;
        data = '0;
        pSel = 1'b0;
        pEnable = 1'b0;
        pWrite = 1'b0;
        pAddr = '0;
        pWdata = '0;
        void'($urandom(28));
        repeat (4) @(posedge clk);
        combin_res <= 1'b1;

        beginTest();
        readAllRegs();
        endTest("reset state");

        beginTest();
        repeat (3) begin
            pickArrivals(0);
            runPassPair(20, 20);
        end
        endTest("two-pass result");

        beginTest();
        pickArrivals(1);
        runPassPair(10, 10);
        pickArrivals(3);
        runPassPair(10, 10);
        endTest("window edges");

        // heavy noise in the fine frame falls mostly outside
        beginTest();
        pickArrivals(0);
        runPassPair(10, 60);
        endTest("out of window");

        beginTest();
        repeat (2) begin
            pickArrivals(0);
            runPassPair(20, 20);
        end
        endTest("status counter");

        // writes everywhere, reads past the map, then readback
        beginTest();
        for (int a = 0; a <= PixelNum; a++) begin
            apbAccess(1'b1, a);
        end
        for (int a = PixelNum + 1; a <= PixelNum + 3; a++) begin
            apbAccess(1'b0, a);
        end
        readAllRegs();
        endTest("apb errors");

        @(negedge clk);
        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 testsRun, testsFailed, checkCount, errCount,
                 i_sifhTop.i_sifhProps.assertErrs);
        if (errCount == 0 && checkCount > 0 && i_sifhTop.i_sifhProps.assertErrs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: sifh.f
sifhPkg.sv
tdcFilter.sv
histogramRam.sv
peakDetector.sv
apbResultRegs.sv
sifhTop.sv
sifh_props.sv
sifhChecker.sv
sifhTb.sv

// File: Bender.yml
package:
  name: sifh

sources:
  - sifhPkg.sv
  - tdcFilter.sv
  - histogramRam.sv
  - peakDetector.sv
  - apbResultRegs.sv
  - sifhTop.sv
  - target: test
    files:
      - sifh_props.sv
      - sifhChecker.sv
      - sifhTb.sv
